//--- hw/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////
	localparam int data_w     = 32;
	localparam int rnum_w     = 5;
	localparam int nregs      = 16;
	localparam int rsel_w     = $clog2(nregs);
	localparam int pc_w       = 6;
	localparam int imem_depth = 64;

	////////////////////////////////////////////////////////////
	// Opcodes, instruction bits 31:26
	////////////////////////////////////////////////////////////
	localparam logic [5:0] op_rtype = 6'd0;
	localparam logic [5:0] op_beq   = 6'd4;
	localparam logic [5:0] op_addi  = 6'd8;
	localparam logic [5:0] op_ori   = 6'd13;
	localparam logic [5:0] op_halt  = 6'd63;

	// R-type function codes, bits 5:0
	localparam logic [5:0] fn_add = 6'd32;
	localparam logic [5:0] fn_sub = 6'd34;
	localparam logic [5:0] fn_and = 6'd36;
	localparam logic [5:0] fn_or  = 6'd37;
	localparam logic [5:0] fn_slt = 6'd42;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_wb,
		st_halted
	} seq_state_t;

endpackage

//--- hw/reg_if.sv
`timescale 1ns/1ps

interface reg_if;
	import cpu_pkg::*;

	logic [rnum_w-1:0] rnum_a;
	logic [rnum_w-1:0] rnum_b;
	logic [rnum_w-1:0] wnum;
	logic [data_w-1:0] wdata;
	logic              we;
	logic [data_w-1:0] rdata_a;
	logic [data_w-1:0] rdata_b;

	modport seq (output rnum_a, rnum_b, wnum, wdata, we, input rdata_a, rdata_b);

	modport rf (input rnum_a, rnum_b, wnum, wdata, we, output rdata_a, rdata_b);

endinterface

//--- hw/regs.sv
`timescale 1ns/1ps

module regs (
	input  logic                      clk,
	input  logic                      rst,
	reg_if.rf                         rf,
	input  logic [3:0]                sw,
	output logic [7:0]                led,
	output logic [cpu_pkg::data_w-1:0] debug_data
);
	import cpu_pkg::*;

	// Register 0 is not stored, it reads as zero
	logic [data_w-1:0] regs_q [1:nregs-1];
	logic              wr_ok;

	// Numbers 0 and 16 and up return zero
	function automatic logic [data_w-1:0] read_reg(input logic [rnum_w-1:0] num);
		logic [data_w-1:0] val;
		val = '0;
		if (num != '0 && num < rnum_w'(nregs))
		begin
			val = regs_q[num[rsel_w-1:0]];
		end
		return val;
	endfunction

	// Writes outside 1..15 are dropped
	assign wr_ok = rf.wnum != '0 && rf.wnum < rnum_w'(nregs);

	////////////////////////////////////////////////////////////
	// Write port, or registered reads when not writing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 1; i < nregs; i++)
			begin
				regs_q[i] <= '0;
			end
			rf.rdata_a <= '0;
			rf.rdata_b <= '0;
			debug_data <= '0;
		end
		else if (rf.we)
		begin
			if (wr_ok)
			begin
				regs_q[rf.wnum[rsel_w-1:0]] <= rf.wdata;
			end
		end
		else
		begin
			rf.rdata_a <= read_reg(rf.rnum_a);
			rf.rdata_b <= read_reg(rf.rnum_b);
			// Debug read follows the switches
			debug_data <= read_reg(rnum_w'(sw));
		end
	end

	// LED tap on r6
	assign led = regs_q[6][7:0];

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [cpu_pkg::data_w-1:0] a,
	input  logic [cpu_pkg::data_w-1:0] b,
	input  cpu_pkg::alu_op_t           op,
	output logic [cpu_pkg::data_w-1:0] result,
	output logic                       zero
);
	import cpu_pkg::*;

	always_comb
	begin
		case (op)
			alu_add:
			begin
				result = a + b;
			end
			alu_sub:
			begin
				result = a - b;
			end
			alu_and:
			begin
				result = a & b;
			end
			alu_or:
			begin
				result = a | b;
			end
			alu_slt:
			begin
				// Signed compare
				result = ($signed(a) < $signed(b)) ? data_w'(1) : '0;
			end
			default:
			begin
				result = a + b;
			end
		endcase
	end

	// Used for beq via subtract
	assign zero = result == '0;

endmodule

//--- hw/imem.sv
`timescale 1ns/1ps

module imem (
	input  logic                       clk,
	input  logic                       we,
	input  logic [cpu_pkg::pc_w-1:0]   waddr,
	input  logic [cpu_pkg::data_w-1:0] wdata,
	input  logic [cpu_pkg::pc_w-1:0]   raddr,
	output logic [cpu_pkg::data_w-1:0] rdata
);
	import cpu_pkg::*;

	logic [data_w-1:0] mem [imem_depth];

	////////////////////////////////////////////////////////////
	// Program load port
	////////////////////////////////////////////////////////////

	// Active in reset as well, so programs load while rst is high
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// Instruction at the current pc
	assign rdata = mem[raddr];

endmodule

//--- hw/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [cpu_pkg::data_w-1:0] instr,
	output logic [cpu_pkg::pc_w-1:0]   pc,
	output logic                       halted,
	reg_if.seq                         rf,
	output logic [cpu_pkg::data_w-1:0] alu_a,
	output logic [cpu_pkg::data_w-1:0] alu_b,
	output cpu_pkg::alu_op_t           alu_op,
	input  logic [cpu_pkg::data_w-1:0] alu_result,
	input  logic                       alu_zero
);
	import cpu_pkg::*;

	seq_state_t        state_q;
	logic [pc_w-1:0]   pc_q;
	logic [data_w-1:0] ir_q;
	logic [data_w-1:0] result_q;

	// Instruction fields
	logic [5:0]        opcode;
	logic [5:0]        funct;
	logic [rnum_w-1:0] rs;
	logic [rnum_w-1:0] rt;
	logic [rnum_w-1:0] rd;
	logic [15:0]       imm;

	logic              writes;
	logic              is_beq;
	logic [rnum_w-1:0] dest;

	assign opcode = ir_q[31:26];
	assign rs     = ir_q[25:21];
	assign rt     = ir_q[20:16];
	assign rd     = ir_q[15:11];
	assign imm    = ir_q[15:0];
	assign funct  = ir_q[5:0];
	assign is_beq = opcode == op_beq;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb
	begin
		alu_op = alu_add;
		alu_b  = rf.rdata_b;
		writes = 1'b0;
		dest   = rt;
		case (opcode)
			op_rtype:
			begin
				dest   = rd;
				writes = 1'b1;
				case (funct)
					fn_add: alu_op = alu_add;
					fn_sub: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or:  alu_op = alu_or;
					fn_slt: alu_op = alu_slt;
					default: writes = 1'b0;
				endcase
			end
			op_addi:
			begin
				writes = 1'b1;
				alu_b  = {{(data_w - 16){imm[15]}}, imm};
			end
			op_ori:
			begin
				writes = 1'b1;
				alu_op = alu_or;
				alu_b  = {{(data_w - 16){1'b0}}, imm};
			end
			op_beq:
			begin
				alu_op = alu_sub;
			end
			default:
			begin
				writes = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state_q <= st_fetch;
			pc_q    <= '0;
			ir_q    <= '0;
		end
		else
		begin
			case (state_q)
				st_fetch:
				begin
					ir_q    <= instr;
					state_q <= st_decode;
				end
				st_decode:
				begin
					// Operands latch in the register file this cycle
					state_q <= (opcode == op_halt) ? st_halted : st_exec;
				end
				st_exec:
				begin
					if (is_beq && alu_zero)
					begin
						pc_q <= pc_q + pc_w'(1) + imm[pc_w-1:0];
					end
					else if (!writes)
					begin
						pc_q <= pc_q + pc_w'(1);
					end
					state_q <= writes ? st_wb : st_fetch;
				end
				st_wb:
				begin
					pc_q    <= pc_q + pc_w'(1);
					state_q <= st_fetch;
				end
				default:
				begin
					state_q <= st_halted;
				end
			endcase
		end
	end

	// Result register
	always_ff @(posedge clk)
	begin
		if (state_q == st_exec)
		begin
			result_q <= alu_result;
		end
	end

	assign alu_a     = rf.rdata_a;
	assign rf.rnum_a = rs;
	assign rf.rnum_b = rt;
	assign rf.wnum   = dest;
	assign rf.wdata  = result_q;
	assign rf.we     = state_q == st_wb;

	assign pc     = pc_q;
	assign halted = state_q == st_halted;

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       prog_we,
	input  logic [cpu_pkg::pc_w-1:0]   prog_addr,
	input  logic [cpu_pkg::data_w-1:0] prog_data,
	input  logic [3:0]                 sw,
	output logic                       halted,
	output logic [cpu_pkg::pc_w-1:0]   pc,
	output logic [7:0]                 led,
	output logic [cpu_pkg::data_w-1:0] debug_data
);
	import cpu_pkg::*;

	logic [data_w-1:0] instr;
	logic [data_w-1:0] alu_a;
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_result;
	logic              alu_zero;
	alu_op_t           alu_op;

	// Sequencer to register file
	reg_if rf_bus ();

	////////////////////////////////////////////////////////////
	// Instruction memory
	////////////////////////////////////////////////////////////
	imem imem_i (
		.clk   (clk),
		.we    (prog_we),
		.waddr (prog_addr),
		.wdata (prog_data),
		.raddr (pc),
		.rdata (instr)
	);

	////////////////////////////////////////////////////////////
	// Control and datapath
	////////////////////////////////////////////////////////////
	cpu_sequencer seq_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.pc         (pc),
		.halted     (halted),
		.rf         (rf_bus.seq),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_op     (alu_op),
		.alu_result (alu_result),
		.alu_zero   (alu_zero)
	);

	alu alu_i (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// Register file with debug read and LED tap
	regs regs_i (
		.clk        (clk),
		.rst        (rst),
		.rf         (rf_bus.rf),
		.sw         (sw),
		.led        (led),
		.debug_data (debug_data)
	);

endmodule

//--- dv/cpu_props.sv
`timescale 1ns/1ps

module regs_props (
	input logic                         clk,
	input logic                         rst,
	input logic                         we,
	input logic [cpu_pkg::rnum_w-1:0]   rnum_a,
	input logic [cpu_pkg::rnum_w-1:0]   rnum_b,
	input logic [cpu_pkg::data_w-1:0]   rdata_a,
	input logic [cpu_pkg::data_w-1:0]   rdata_b
);
	import cpu_pkg::*;

	logic zero_a;
	logic zero_b;

	// Register 0 and numbers 16 and up
	assign zero_a = rnum_a == '0 || rnum_a >= rnum_w'(nregs);
	assign zero_b = rnum_b == '0 || rnum_b >= rnum_w'(nregs);

	////////////////////////////////////////////////////////////
	// Read port behavior
	////////////////////////////////////////////////////////////
	hold_after_write: assert property (@(posedge clk) disable iff (rst)
		we |=> $stable(rdata_a) && $stable(rdata_b))
		else $error("operand read data changed in the cycle after a write");

	zero_read_a: assert property (@(posedge clk) disable iff (rst)
		!we && zero_a |=> rdata_a == '0)
		else $error("port a read of register 0 or 16 and up was not zero");

	zero_read_b: assert property (@(posedge clk) disable iff (rst)
		!we && zero_b |=> rdata_b == '0)
		else $error("port b read of register 0 or 16 and up was not zero");

	// No write strobe while in reset
	quiet_in_reset: assert property (@(posedge clk) rst |-> !we)
		else $error("write strobe high during reset");

endmodule

bind regs regs_props props_i (
	.clk     (clk),
	.rst     (rst),
	.we      (rf.we),
	.rnum_a  (rf.rnum_a),
	.rnum_b  (rf.rnum_b),
	.rdata_a (rf.rdata_a),
	.rdata_b (rf.rdata_b)
);

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int n_prog     = 23;
	localparam int n_checks   = 16;
	localparam int step_limit = 1000;

	logic              clk;
	logic              rst;
	logic              prog_we;
	logic [pc_w-1:0]   prog_addr;
	logic [data_w-1:0] prog_data;
	logic [3:0]        sw;
	logic              halted;
	logic [pc_w-1:0]   pc;
	logic [7:0]        led;
	logic [data_w-1:0] debug_data;

	// Program table and ISA model state
	logic [data_w-1:0] prog [n_prog];
	logic [data_w-1:0] model_regs [nregs];
	logic [pc_w-1:0]   model_pc;
	int                n_exec;

	// Debug port check table
	string             check_name [n_checks];
	logic [3:0]        check_sw [n_checks];
	logic [data_w-1:0] check_exp [n_checks];

	int                seed;
	int                cycle_limit;
	int                cycles;

	cpu_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.sw         (sw),
		.halted     (halted),
		.pc         (pc),
		.led        (led),
		.debug_data (debug_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			report_failure($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program();
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		logic [15:0] imm_c;
		logic [15:0] imm_d;
		// Positive r1 so slt against r5 sees mixed signs
		imm_a = 16'($random(seed)) & 16'h7fff;
		imm_b = 16'($random(seed)) | 16'h8000;
		imm_c = 16'($random(seed)) | 16'h8000;
		imm_d = 16'($random(seed));
		prog[0]  = enc_i(op_addi, 0, 1, imm_a);
		prog[1]  = enc_i(op_ori, 0, 2, imm_b);
		prog[2]  = enc_i(op_addi, 0, 3, imm_c);
		prog[3]  = enc_i(op_ori, 0, 4, imm_d);
		prog[4]  = enc_i(op_addi, 0, 5, 16'hfff9);
		prog[5]  = enc_r(1, 2, 6, fn_add);
		prog[6]  = enc_r(0, 2, 7, fn_sub);
		prog[7]  = enc_r(1, 4, 8, fn_and);
		prog[8]  = enc_r(2, 3, 9, fn_or);
		prog[9]  = enc_r(5, 1, 10, fn_slt);
		prog[10] = enc_r(3, 5, 11, fn_slt);
		// Writes that must be dropped
		prog[11] = enc_i(op_addi, 0, 0, 16'd5);
		prog[12] = enc_r(1, 2, 17, fn_add);
		prog[13] = enc_i(op_addi, 1, 20, 16'd9);
		// Taken branch over r12 and r13
		prog[14] = enc_i(op_beq, 1, 1, 16'd2);
		prog[15] = enc_i(op_addi, 0, 12, 16'd111);
		prog[16] = enc_i(op_addi, 0, 13, 16'd222);
		prog[17] = enc_r(20, 3, 12, fn_add);
		prog[18] = enc_i(op_ori, 0, 14, 16'h0055);
		prog[19] = enc_i(op_beq, 14, 0, 16'd1);
		prog[20] = enc_i(op_addi, 14, 15, 16'h0044);
		prog[21] = enc_i(6'd2, 0, 0, 16'h0003);
		prog[22] = enc_i(op_halt, 0, 0, 16'h0000);
	endtask

	////////////////////////////////////////////////////////////
	// ISA reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] model_read(input logic [4:0] num);
		logic [31:0] val;
		val = '0;
		if (num != 5'd0 && num < 5'd16)
		begin
			val = model_regs[num[3:0]];
		end
		return val;
	endfunction

	task automatic run_model();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        wr;
		logic        done;
		int          steps;
		for (int i = 0; i < nregs; i++)
		begin
			model_regs[i] = '0;
		end
		model_pc = '0;
		n_exec   = 0;
		done     = 1'b0;
		steps    = 0;
		while (!done && steps < step_limit)
		begin
			ins = (int'(model_pc) < n_prog) ? prog[model_pc] : {op_halt, 26'd0};
			a = model_read(ins[25:21]);
			b = model_read(ins[20:16]);
			wr   = 1'b0;
			dest = ins[20:16];
			res  = '0;
			n_exec++;
			steps++;
			if (ins[31:26] == op_halt)
			begin
				done = 1'b1;
			end
			else if (ins[31:26] == op_beq)
			begin
				model_pc = (a == b) ? model_pc + 6'd1 + ins[5:0] : model_pc + 6'd1;
			end
			else
			begin
				case (ins[31:26])
					op_rtype:
					begin
						dest = ins[15:11];
						wr   = 1'b1;
						case (ins[5:0])
							fn_add: res = a + b;
							fn_sub: res = a - b;
							fn_and: res = a & b;
							fn_or:  res = a | b;
							fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
							default: wr = 1'b0;
						endcase
					end
					op_addi:
					begin
						wr  = 1'b1;
						res = a + {{16{ins[15]}}, ins[15:0]};
					end
					op_ori:
					begin
						wr  = 1'b1;
						res = a | {16'h0000, ins[15:0]};
					end
					default: wr = 1'b0;
				endcase
				// Only registers 1 to 15 take writes
				if (wr && dest != 5'd0 && dest < 5'd16)
				begin
					model_regs[dest[3:0]] = res;
				end
				model_pc = model_pc + 6'd1;
			end
		end
	endtask

	// Watchdog from reset release
	initial
	begin
		cycles = 0;
		@(negedge rst);
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		report_failure($sformatf("timeout after %0d cycles without finishing", cycles));
	end

	initial
	begin
		rst       = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		sw        = '0;
		seed      = 85088;
		build_program();
		run_model();
		for (int k = 0; k < n_checks; k++)
		begin
			check_name[k] = $sformatf("debug r%0d", k);
			check_sw[k]   = 4'(k);
			check_exp[k]  = model_regs[k];
		end
		cycle_limit = 4 * n_exec + 50;

		// Program load under reset
		for (int i = 0; i < n_prog; i++)
		begin
			@(negedge clk);
			prog_we   = 1'b1;
			prog_addr = pc_w'(i);
			prog_data = prog[i];
		end
		@(negedge clk);
		prog_we = 1'b0;

		// Reset state for every switch value
		for (int i = 0; i < 16; i++)
		begin
			sw = 4'(i);
			@(negedge clk);
			check_value("halted in reset", '0, data_w'(halted));
			check_value("pc in reset", '0, data_w'(pc));
			check_value($sformatf("debug sw=%0d in reset", i), '0, debug_data);
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;

		while (!halted)
		begin
			@(negedge clk);
		end
		check_value("pc at halt", data_w'(model_pc), data_w'(pc));
		check_value("led", data_w'(model_regs[6][7:0]), data_w'(led));

		////////////////////////////////////////////////////////////
		// Register contents through the debug port
		////////////////////////////////////////////////////////////
		for (int k = 0; k < n_checks; k++)
		begin
			sw = check_sw[k];
			repeat (2) @(negedge clk);
			check_value(check_name[k], check_exp[k], debug_data);
			check_value("halted held", 32'd1, data_w'(halted));
			check_value("pc held", data_w'(model_pc), data_w'(pc));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- all.f
hw/cpu_pkg.sv
hw/reg_if.sv
hw/regs.sv
hw/alu.sv
hw/imem.sv
hw/cpu_sequencer.sv
hw/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f all.f -o cpu_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
